//--- Bender.yml
package:
  name: vga_display

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vga_pkg.sv
      - rtl/vga_timing.sv
      - rtl/vram_fetch.sv
      - rtl/pixel_shift.sv
      - rtl/vga_output.sv
      - rtl/vga_display.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/wb_vram_slave.sv
      - tb/vga_display_tb.sv

//--- compile.f
+incdir+rtl
rtl/vga_pkg.sv
rtl/vga_timing.sv
rtl/vram_fetch.sv
rtl/pixel_shift.sv
rtl/vga_output.sv
rtl/vga_display.sv
tb/wb_vram_slave.sv
tb/vga_display_tb.sv

//--- rtl/pixel_shift.sv
// Second VGA stage that serialises VRAM words into one pixel per clock, LSB first
`timescale 1ns/10ps

module pixel_shift (
   input  logic           vga_clk,
   input  logic           reset,
   input  vga_pkg::beam_t beam_in,
   input  logic [31:0]    hold_word,
   input  logic           hold_full,
   output vga_pkg::beam_t beam_out,
   output logic           pixel
);

   logic [31:0] shift_reg;

   ////////////////////////////////////////
   // Shift register

   // Missing word shows as black
   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset) begin
         shift_reg <= '0;
      end else if (beam_in.word_load) begin
         shift_reg <= hold_full ? hold_word : 32'd0;
      end else begin
         shift_reg <= {1'b0, shift_reg[31:1]};
      end
   end

   ////////////////////////////////////////
   // Stage register

   // Bit 0 of a fresh word lines up with the first box column
   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset) begin
         beam_out <= '0;
         pixel <= 1'b0;
      end else begin
         beam_out <= beam_in;
         pixel <= shift_reg[0];
      end
   end

endmodule

//--- rtl/vga_defines.svh
// Raster, box and fetch timing constants for the VGA engine, included by the package and RTL
`ifndef VGA_DEFINES_SVH
`define VGA_DEFINES_SVH

////////////////////////////////////////
// Horizontal raster, in pixels

`define VGA_H_DISP 640
`define VGA_H_FPORCH 16
`define VGA_H_SYNC 96
`define VGA_H_BPORCH 48

////////////////////////////////////////
// Vertical raster, in lines

`define VGA_V_DISP 480
`define VGA_V_FPORCH 10
`define VGA_V_SYNC 2
`define VGA_V_BPORCH 33

////////////////////////////////////////
// Picture box inside the visible area

// Left column and width, width in whole 32-pixel words
`define VGA_BOX_X 64
`define VGA_BOX_W 512

// Top row and height
`define VGA_BOX_Y 16
`define VGA_BOX_H 448

////////////////////////////////////////
// VRAM fetch

// Lead of the first request of a line, in columns before the box
`define VGA_PREFETCH 40

// Word address width of the VRAM port
`define VGA_ADR_W 13

`endif

//--- rtl/vga_display.sv
// Top of the monochrome VGA engine with its timing, shift, output and VRAM fetch blocks
`timescale 1ns/10ps

module vga_display (
   input  logic              vga_clk,
   input  logic              reset,
   output vga_pkg::wb_m2s_t  wb_o,
   input  vga_pkg::wb_s2m_t  wb_i,
   output vga_pkg::vga_out_t video
);

   // Beam out of the timing stage and out of the shifter
   vga_pkg::beam_t beam;
   vga_pkg::beam_t beam_px;
   logic [31:0]    hold_word;
   logic           hold_full;
   logic           pixel;

   ////////////////////////////////////////
   // Pipeline

   vga_timing i_vga_timing (
      .vga_clk (vga_clk),
      .reset   (reset),
      .beam    (beam)
   );

   pixel_shift i_pixel_shift (
      .vga_clk   (vga_clk),
      .reset     (reset),
      .beam_in   (beam),
      .hold_word (hold_word),
      .hold_full (hold_full),
      .beam_out  (beam_px),
      .pixel     (pixel)
   );

   vga_output i_vga_output (
      .vga_clk (vga_clk),
      .reset   (reset),
      .beam    (beam_px),
      .pixel   (pixel),
      .video   (video)
   );

   ////////////////////////////////////////
   // VRAM read master

   vram_fetch i_vram_fetch (
      .vga_clk   (vga_clk),
      .reset     (reset),
      .beam      (beam),
      .wb_o      (wb_o),
      .wb_i      (wb_i),
      .hold_word (hold_word),
      .hold_full (hold_full)
   );

endmodule

//--- rtl/vga_output.sv
// Third VGA stage that mixes pixel, border and blanking into the registered video outputs
`timescale 1ns/10ps

module vga_output (
   input  logic             vga_clk,
   input  logic             reset,
   input  vga_pkg::beam_t   beam,
   input  logic             pixel,
   output vga_pkg::vga_out_t video
);

   logic colour;

   // Box shows the pixel, border is white, rest black
   assign colour = beam.in_box ? pixel : beam.in_border;

   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset) begin
         video.r <= 1'b0;
         video.g <= 1'b0;
         video.b <= 1'b0;
         video.hsync <= 1'b0;
         video.vsync <= 1'b0;
         video.blank <= 1'b1;
      end else begin
         video.r <= colour;
         video.g <= colour;
         video.b <= colour;
         video.hsync <= beam.hsync;
         video.vsync <= beam.vsync;
         video.blank <= !beam.active;
      end
   end

endmodule

//--- rtl/vga_pkg.sv
// Shared struct types of the VGA engine, referenced by scoped name from each module
`include "vga_defines.svh"

package vga_pkg;

   ////////////////////////////////////////
   // Decoded raster position

   typedef struct packed {
      // Sync pulses, active high
      logic       hsync;
      logic       vsync;
      // Visible area
      logic       active;
      logic       in_box;
      logic       in_border;
      // One cycle ahead of each 32-pixel word
      logic       word_load;
      // Start of the line fetch
      logic       line_pre;
      // Box row, zero outside the box
      logic [8:0] row;
   } beam_t;

   ////////////////////////////////////////
   // Wishbone classic, read only

   typedef struct packed {
      logic                  cyc;
      logic                  stb;
      logic [`VGA_ADR_W-1:0] adr;
   } wb_m2s_t;

   typedef struct packed {
      logic        ack;
      logic [31:0] dat;
   } wb_s2m_t;

   ////////////////////////////////////////
   // Video output

   // Monochrome, so r, g and b always match
   typedef struct packed {
      logic r;
      logic g;
      logic b;
      logic hsync;
      logic vsync;
      logic blank;
   } vga_out_t;

endpackage

//--- rtl/vga_timing.sv
// First VGA stage that runs the raster counters and registers the decoded beam for later stages
`timescale 1ns/10ps
`include "vga_defines.svh"

module vga_timing (
   input  logic           vga_clk,
   input  logic           reset,
   output vga_pkg::beam_t beam
);

   // Horizontal positions
   localparam logic [10:0] H_LAST = 11'(`VGA_H_DISP + `VGA_H_FPORCH + `VGA_H_SYNC
                                         + `VGA_H_BPORCH - 1);
   localparam logic [10:0] H_DISP = 11'(`VGA_H_DISP);
   localparam logic [10:0] H_SYNC_ON = 11'(`VGA_H_DISP + `VGA_H_FPORCH);
   localparam logic [10:0] H_SYNC_OFF = 11'(`VGA_H_DISP + `VGA_H_FPORCH + `VGA_H_SYNC);
   localparam logic [10:0] H_BORDER_L = 11'(`VGA_BOX_X - 1);
   localparam logic [10:0] H_BOX_FIRST = 11'(`VGA_BOX_X);
   localparam logic [10:0] H_BORDER_R = 11'(`VGA_BOX_X + `VGA_BOX_W);
   localparam logic [10:0] H_LOAD_END = 11'(`VGA_BOX_X + `VGA_BOX_W - 1);
   localparam logic [10:0] H_PRE = 11'(`VGA_BOX_X - `VGA_PREFETCH);

   // Vertical positions
   localparam logic [9:0] V_LAST = 10'(`VGA_V_DISP + `VGA_V_FPORCH + `VGA_V_SYNC
                                       + `VGA_V_BPORCH - 1);
   localparam logic [9:0] V_DISP = 10'(`VGA_V_DISP);
   localparam logic [9:0] V_SYNC_ON = 10'(`VGA_V_DISP + `VGA_V_FPORCH);
   localparam logic [9:0] V_SYNC_OFF = 10'(`VGA_V_DISP + `VGA_V_FPORCH + `VGA_V_SYNC);
   localparam logic [9:0] V_BORDER_T = 10'(`VGA_BOX_Y - 1);
   localparam logic [9:0] V_BOX_FIRST = 10'(`VGA_BOX_Y);
   localparam logic [9:0] V_BORDER_B = 10'(`VGA_BOX_Y + `VGA_BOX_H);

   logic [10:0]    h_cnt;
   logic [9:0]     v_cnt;
   logic           h_box;
   logic           v_box;
   logic           h_frame;
   logic           v_edge;
   logic [10:0]    word_col;
   vga_pkg::beam_t beam_nxt;

   ////////////////////////////////////////
   // Raster counters

   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (h_cnt == H_LAST) begin
         h_cnt <= '0;
         if (v_cnt == V_LAST) begin
            v_cnt <= '0;
         end else begin
            v_cnt <= v_cnt + 10'd1;
         end
      end else begin
         h_cnt <= h_cnt + 11'd1;
      end
   end

   ////////////////////////////////////////
   // Beam decode

   always_comb begin
      h_box = (h_cnt >= H_BOX_FIRST) && (h_cnt < H_BORDER_R);
      v_box = (v_cnt >= V_BOX_FIRST) && (v_cnt < V_BORDER_B);
      // Columns spanned by the top and bottom border lines
      h_frame = (h_cnt >= H_BORDER_L) && (h_cnt <= H_BORDER_R);
      v_edge = (v_cnt == V_BORDER_T) || (v_cnt == V_BORDER_B);
      word_col = h_cnt - H_BORDER_L;

      beam_nxt.hsync = (h_cnt >= H_SYNC_ON) && (h_cnt < H_SYNC_OFF);
      beam_nxt.vsync = (v_cnt >= V_SYNC_ON) && (v_cnt < V_SYNC_OFF);
      beam_nxt.active = (h_cnt < H_DISP) && (v_cnt < V_DISP);
      beam_nxt.in_box = h_box && v_box;
      beam_nxt.in_border = (v_box && ((h_cnt == H_BORDER_L) || (h_cnt == H_BORDER_R)))
                           || (v_edge && h_frame);
      // Every 32 columns starting one column left of the box
      beam_nxt.word_load = v_box && (h_cnt >= H_BORDER_L) && (h_cnt < H_LOAD_END)
                           && (word_col[4:0] == 5'd0);
      beam_nxt.line_pre = v_box && (h_cnt == H_PRE);
      beam_nxt.row = v_box ? 9'(v_cnt - V_BOX_FIRST) : 9'd0;
   end

   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset) begin
         beam <= '0;
      end else begin
         beam <= beam_nxt;
      end
   end

endmodule

//--- rtl/vram_fetch.sv
// Wishbone classic read master that prefetches one VRAM word at a time into a hold register
`timescale 1ns/10ps
`include "vga_defines.svh"

module vram_fetch (
   input  logic             vga_clk,
   input  logic             reset,
   input  vga_pkg::beam_t   beam,
   output vga_pkg::wb_m2s_t wb_o,
   input  vga_pkg::wb_s2m_t wb_i,
   output logic [31:0]      hold_word,
   output logic             hold_full
);

   localparam int ADR_W = `VGA_ADR_W;
   localparam int WORDS = `VGA_BOX_W / 32;
   localparam int CNT_W = $clog2(WORDS + 1);

   logic             req;
   logic [ADR_W-1:0] adr;
   // Words of the line not yet fetched
   logic [CNT_W-1:0] left;
   logic             ack_in;

   // Acks outside a cycle are ignored
   assign ack_in = req && wb_i.ack;

   ////////////////////////////////////////
   // Request and address

   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset) begin
         req <= 1'b0;
         adr <= '0;
         left <= '0;
      end else if (beam.line_pre) begin
         // First word of the box row
         req <= 1'b1;
         adr <= ADR_W'(beam.row) * ADR_W'(WORDS);
         left <= CNT_W'(WORDS);
      end else if (ack_in) begin
         req <= 1'b0;
         adr <= adr + 1'b1;
         left <= left - 1'b1;
      end else if (beam.word_load && !req && (left != '0)) begin
         // Hold register drains now, refill it
         req <= 1'b1;
      end
   end

   // cyc and stb always move together
   assign wb_o.cyc = req;
   assign wb_o.stb = req;
   assign wb_o.adr = adr;

   ////////////////////////////////////////
   // Hold register

   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset) begin
         hold_word <= '0;
      end else if (ack_in) begin
         hold_word <= wb_i.dat;
      end
   end

   // pixel_shift takes the word on the same word_load pulse
   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset) begin
         hold_full <= 1'b0;
      end else if (ack_in) begin
         hold_full <= 1'b1;
      end else if (beam.word_load || beam.line_pre) begin
         hold_full <= 1'b0;
      end
   end

endmodule

//--- tb/vga_display_tb.sv
// Testbench for the VGA engine that checks every output cycle against a raster model and the VRAM
`timescale 1ns/10ps
`include "vga_defines.svh"

module vga_display_tb;

   localparam int H_TOTAL = `VGA_H_DISP + `VGA_H_FPORCH + `VGA_H_SYNC + `VGA_H_BPORCH;
   localparam int V_TOTAL = `VGA_V_DISP + `VGA_V_FPORCH + `VGA_V_SYNC + `VGA_V_BPORCH;
   localparam int WORDS = `VGA_BOX_W / 32;
   localparam int BOX_WORDS = WORDS * `VGA_BOX_H;
   localparam int FRAMES = 2;
   localparam int CYCLE_LIMIT = FRAMES * H_TOTAL * V_TOTAL + 1000;
   localparam int MAX_SHOWN = 10;

   logic              vga_clk = 1'b0;
   logic              reset = 1'b1;
   vga_pkg::wb_m2s_t  wb_m2s;
   vga_pkg::wb_s2m_t  wb_s2m;
   vga_pkg::vga_out_t video;

   // Raster position the outputs show now
   int    mh = 0;
   int    mv = 0;
   int    mframe = 0;
   int    checks [5] = '{default: 0};
   int    errors [5] = '{default: 0};
   string names [5] = '{"reset state", "sync and blank", "box pixels",
                        "border and background", "wishbone reads"};
   int    cycles = 0;
   int    total_errors = 0;
   int    failed = 0;
   // Wishbone monitor state
   logic                  ack_q = 1'b0;
   logic                  pend = 1'b0;
   logic [`VGA_ADR_W-1:0] pend_adr;
   int                    reads_started = 0;
   int                    reads_done = 0;

   vga_display i_vga_display (
      .vga_clk (vga_clk),
      .reset   (reset),
      .wb_o    (wb_m2s),
      .wb_i    (wb_s2m),
      .video   (video)
   );

   wb_vram_slave i_wb_vram_slave (
      .vga_clk (vga_clk),
      .reset   (reset),
      .wb_i    (wb_m2s),
      .wb_o    (wb_s2m)
   );

   always #20 vga_clk = ~vga_clk;

   // ack is stable at the rising edge
   always @(posedge vga_clk) ack_q = wb_s2m.ack;

   always @(posedge vga_clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
         $display("Something failed");
         $finish;
      end
   end

   //////////////////////////////////////////
   // Reference raster model

   function automatic logic inside_box(input int h, input int v);
      return (h >= `VGA_BOX_X) && (h < `VGA_BOX_X + `VGA_BOX_W)
             && (v >= `VGA_BOX_Y) && (v < `VGA_BOX_Y + `VGA_BOX_H);
   endfunction

   function automatic vga_pkg::vga_out_t expected_video(input int h, input int v);
      vga_pkg::vga_out_t exp;
      logic              box_row;
      logic              colour;
      int                word;
      box_row = (v >= `VGA_BOX_Y) && (v < `VGA_BOX_Y + `VGA_BOX_H);
      if (inside_box(h, v)) begin
         // Bit 0 of each word is the leftmost pixel
         word = (v - `VGA_BOX_Y) * WORDS + (h - `VGA_BOX_X) / 32;
         colour = i_wb_vram_slave.mem[word][(h - `VGA_BOX_X) % 32];
      end else begin
         // Top and bottom border rows include the corners
         colour = (box_row && (h == `VGA_BOX_X - 1 || h == `VGA_BOX_X + `VGA_BOX_W))
                  || ((v == `VGA_BOX_Y - 1 || v == `VGA_BOX_Y + `VGA_BOX_H)
                      && h >= `VGA_BOX_X - 1 && h <= `VGA_BOX_X + `VGA_BOX_W);
      end
      exp.r = colour;
      exp.g = colour;
      exp.b = colour;
      exp.hsync = (h >= `VGA_H_DISP + `VGA_H_FPORCH)
                  && (h < `VGA_H_DISP + `VGA_H_FPORCH + `VGA_H_SYNC);
      exp.vsync = (v >= `VGA_V_DISP + `VGA_V_FPORCH)
                  && (v < `VGA_V_DISP + `VGA_V_FPORCH + `VGA_V_SYNC);
      exp.blank = !((h < `VGA_H_DISP) && (v < `VGA_V_DISP));
      return exp;
   endfunction

   task automatic advance_model();
      if (mh == H_TOTAL - 1) begin
         mh = 0;
         if (mv == V_TOTAL - 1) begin
            mv = 0;
            mframe++;
         end else begin
            mv++;
         end
      end else begin
         mh++;
      end
   endtask

   //////////////////////////////////////////
   // Checks

   task automatic report_mismatch(input int t, input string name, input logic [31:0] exp_val,
                                  input logic [31:0] act_val);
      errors[t]++;
      if (errors[t] <= MAX_SHOWN) begin
         $display("error: %s expected 0x%0h actual 0x%0h at h %0d v %0d frame %0d",
                  name, exp_val, act_val, mh, mv, mframe);
      end
   endtask

   task automatic report_problem(input int t, input string what);
      errors[t]++;
      if (errors[t] <= MAX_SHOWN) begin
         $display("failure in %s: %s at h %0d v %0d frame %0d", names[t], what, mh, mv, mframe);
      end
   endtask

   task automatic check_reset_state();
      checks[0] += 8;
      if (wb_m2s.cyc !== 1'b0) report_mismatch(0, "cyc", 0, wb_m2s.cyc);
      if (wb_m2s.stb !== 1'b0) report_mismatch(0, "stb", 0, wb_m2s.stb);
      if (video.r !== 1'b0) report_mismatch(0, "r", 0, video.r);
      if (video.g !== 1'b0) report_mismatch(0, "g", 0, video.g);
      if (video.b !== 1'b0) report_mismatch(0, "b", 0, video.b);
      if (video.hsync !== 1'b0) report_mismatch(0, "hsync", 0, video.hsync);
      if (video.vsync !== 1'b0) report_mismatch(0, "vsync", 0, video.vsync);
      if (video.blank !== 1'b1) report_mismatch(0, "blank", 1, video.blank);
   endtask

   task automatic check_video();
      vga_pkg::vga_out_t exp;
      int                t;
      exp = expected_video(mh, mv);
      checks[1] += 3;
      if (video.hsync !== exp.hsync) report_mismatch(1, "hsync", exp.hsync, video.hsync);
      if (video.vsync !== exp.vsync) report_mismatch(1, "vsync", exp.vsync, video.vsync);
      if (video.blank !== exp.blank) report_mismatch(1, "blank", exp.blank, video.blank);
      // Box pixels and the rest of the raster count separately
      if (inside_box(mh, mv)) begin
         t = 2;
      end else begin
         t = 3;
      end
      checks[t] += 3;
      if (video.r !== exp.r) report_mismatch(t, "r", exp.r, video.r);
      if (video.g !== exp.g) report_mismatch(t, "g", exp.g, video.g);
      if (video.b !== exp.b) report_mismatch(t, "b", exp.b, video.b);
   endtask

   task automatic check_wishbone();
      // Read ended on the last rising edge
      if (pend && ack_q) begin
         pend = 1'b0;
         reads_done++;
         checks[4]++;
         if (wb_m2s.cyc) report_problem(4, "cyc still high in the cycle after ack");
      end
      checks[4]++;
      if (wb_m2s.stb && !wb_m2s.cyc) report_problem(4, "stb high while cyc is low");
      if (wb_m2s.cyc && !pend) begin
         // Addresses run on row by row from word 0 of each frame
         pend = 1'b1;
         pend_adr = wb_m2s.adr;
         checks[4]++;
         if (wb_m2s.adr !== `VGA_ADR_W'(reads_started % BOX_WORDS)) begin
            report_mismatch(4, "adr", reads_started % BOX_WORDS, wb_m2s.adr);
         end
         reads_started++;
      end else if (wb_m2s.cyc) begin
         checks[4]++;
         if (wb_m2s.adr !== pend_adr) report_mismatch(4, "adr", pend_adr, wb_m2s.adr);
      end
   endtask

   // Every read of a box row ends before the row does
   task automatic check_row_reads();
      int exp_reads;
      if (mh == H_TOTAL - 1 && mv >= `VGA_BOX_Y && mv < `VGA_BOX_Y + `VGA_BOX_H) begin
         exp_reads = mframe * BOX_WORDS + (mv - `VGA_BOX_Y + 1) * WORDS;
         checks[4]++;
         if (reads_done != exp_reads) report_mismatch(4, "reads", exp_reads, reads_done);
      end
   endtask

   //////////////////////////////////////////
   // Run

   initial begin
      void'($urandom(20199));
      i_wb_vram_slave.fill_random();
      for (int i = 0; i < 3; i++) begin
         @(negedge vga_clk);
         check_reset_state();
      end
      reset = 1'b0;
      @(negedge vga_clk);
      check_reset_state();
      $display("test 1 %s: %0d checks, %0d errors", names[0], checks[0], errors[0]);
      // Pipeline fills for one more cycle, then position (0, 0) shows
      @(negedge vga_clk);
      for (int n = 0; n < FRAMES * H_TOTAL * V_TOTAL; n++) begin
         @(negedge vga_clk);
         check_wishbone();
         check_video();
         check_row_reads();
         advance_model();
      end
      checks[4]++;
      if (reads_done != FRAMES * BOX_WORDS) begin
         report_mismatch(4, "reads", FRAMES * BOX_WORDS, reads_done);
      end
      for (int t = 1; t < 5; t++) begin
         $display("test %0d %s: %0d checks, %0d errors", t + 1, names[t], checks[t], errors[t]);
      end
      for (int t = 0; t < 5; t++) begin
         total_errors += errors[t];
         if (errors[t] != 0) failed++;
      end
      $display("tests run 5, passed %0d, failed %0d, errors %0d", 5 - failed, failed,
               total_errors);
      if (total_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

//--- tb/wb_vram_slave.sv
// Testbench Wishbone classic slave modelling the VRAM with random contents and random wait states
`timescale 1ns/10ps
`include "vga_defines.svh"

module wb_vram_slave (
   input  logic             vga_clk,
   input  logic             reset,
   input  vga_pkg::wb_m2s_t wb_i,
   output vga_pkg::wb_s2m_t wb_o
);

   localparam int DEPTH = (`VGA_BOX_W / 32) * `VGA_BOX_H;
   localparam int MAX_WAIT = 8;

   logic [31:0]      mem [0:DEPTH-1];
   logic             busy;
   int               wait_left;
   vga_pkg::wb_s2m_t resp;

   // Bus idle while reset is high
   assign wb_o = reset ? '0 : resp;

   // Filled once the seed is set
   task automatic fill_random();
      for (int i = 0; i < DEPTH; i++) begin
         mem[i] = $urandom;
      end
   endtask

   ////////////////////////////////////////
   // Read response

   // Driven on the falling edge, the master samples ack on the rising edge
   always @(negedge vga_clk or posedge reset) begin
      int wait_now;
      if (reset) begin
         resp <= '0;
         busy <= 1'b0;
         wait_left <= 0;
      end else if (resp.ack) begin
         // Master drops cyc after this ack
         resp.ack <= 1'b0;
      end else if (wb_i.cyc && wb_i.stb) begin
         if (busy) begin
            wait_now = wait_left;
         end else begin
            wait_now = $urandom % (MAX_WAIT + 1);
         end
         if (wait_now == 0) begin
            resp.ack <= 1'b1;
            resp.dat <= mem[wb_i.adr];
            busy <= 1'b0;
         end else begin
            busy <= 1'b1;
            wait_left <= wait_now - 1;
         end
      end
   end

endmodule
